/* verilog/isa_pkg.sv */
// ISA level types for the out-of-order integer core
// data words, register numbers, ALU opcodes and the two outside port packets
// imported by the pipeline package and by every module that sees a port
package isa_pkg;

    typedef logic [31:0] data_t;      // one data word
    typedef logic [4:0]  arch_reg_t;  // r0..r31, no hardwired zero

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi                       // b comes from imm
    } alu_op_e;

    // dispatch port, held by the driver while stalled
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;              // ignored for addi
        data_t     imm;
    } inst_t;

    // retire port, one pulse per instruction in program order
    typedef struct packed {
        logic      valid;
        arch_reg_t dest;
        data_t     value;
    } retire_t;

endpackage

/* verilog/ooo_pkg.sv */
// out-of-order pipeline types
// physical tags, the common data bus and the packets that flow between
// dispatch, the reservation station, the ALU and the reorder buffer
package ooo_pkg;

    parameter int num_phys_regs = 64;

    typedef logic [$clog2(num_phys_regs)-1:0] phys_tag_t;

    // result broadcast, one per cycle from the single ALU
    typedef struct packed {
        logic          valid;
        phys_tag_t     tag;
        isa_pkg::data_t value;
    } cdb_t;

    // waiting instruction in the RS
    typedef struct packed {
        isa_pkg::alu_op_e op;
        phys_tag_t        dest_tag;
        phys_tag_t        src1_tag;
        logic             src1_ready;
        phys_tag_t        src2_tag;
        logic             src2_ready;  // forced high for addi
        isa_pkg::data_t   imm;
    } rs_entry_t;

    // RS to ALU, operands already read
    typedef struct packed {
        logic             valid;
        isa_pkg::alu_op_e op;
        phys_tag_t        dest_tag;
        isa_pkg::data_t   a;
        isa_pkg::data_t   b;
    } issue_t;

    typedef struct packed {
        isa_pkg::arch_reg_t dest;
        phys_tag_t          new_tag;   // matched against the CDB
        phys_tag_t          old_tag;   // freed at retire
        logic               done;
        isa_pkg::data_t     value;
    } rob_entry_t;

endpackage

/* verilog/dispatch_stage.sv */
// rename and dispatch, purely combinational
// forms the stall and the alloc strobe shared by map table, free list,
// RS and ROB, and builds the RS and ROB packets from the rename results
`timescale 1ns/1ps

module dispatch_stage (
    input  isa_pkg::inst_t      inst,
    input  logic                rs_full,
    input  logic                rob_full,
    input  logic                fl_empty,
    input  ooo_pkg::phys_tag_t  free_tag,
    input  ooo_pkg::phys_tag_t  src1_tag,
    input  logic                src1_ready,
    input  ooo_pkg::phys_tag_t  src2_tag,
    input  logic                src2_ready,
    input  ooo_pkg::phys_tag_t  old_tag,
    output logic                alloc,
    output ooo_pkg::rs_entry_t  rs_entry,
    output ooo_pkg::rob_entry_t rob_entry,
    output logic                dispatch_stall
);
    import ooo_pkg::*;
    import isa_pkg::*;

    logic is_addi;

    // stall from unit state only, never from inst
    assign dispatch_stall = rs_full | rob_full | fl_empty;
    assign alloc          = inst.valid & ~dispatch_stall;
    assign is_addi        = (inst.op == op_addi);

    always_comb begin
        rs_entry.op         = inst.op;
        rs_entry.dest_tag   = free_tag;          // new mapping
        rs_entry.src1_tag   = src1_tag;
        rs_entry.src1_ready = src1_ready;
        rs_entry.src2_tag   = is_addi ? '0 : src2_tag;   // unused for addi
        rs_entry.src2_ready = is_addi | src2_ready;
        rs_entry.imm        = inst.imm;

        rob_entry.dest      = inst.dest;
        rob_entry.new_tag   = free_tag;
        rob_entry.old_tag   = old_tag;           // recycled at retire
        rob_entry.done      = 1'b0;
        rob_entry.value     = '0;
    end

endmodule

/* verilog/map_table.sv */
// speculative rename map, architectural register to physical tag
// combinational lookups with CDB forwarding of the ready bit,
// allocation writes the new tag and returns the old one
`timescale 1ns/1ps

module map_table (
    input  logic               clock,
    input  logic               reset,
    input  isa_pkg::arch_reg_t lookup1,
    input  isa_pkg::arch_reg_t lookup2,
    input  logic               alloc,
    input  isa_pkg::arch_reg_t alloc_ar,
    input  ooo_pkg::phys_tag_t alloc_tag,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::phys_tag_t src1_tag,
    output logic               src1_ready,
    output ooo_pkg::phys_tag_t src2_tag,
    output logic               src2_ready,
    output ooo_pkg::phys_tag_t old_tag
);
    import ooo_pkg::*;

    phys_tag_t   tags [32];
    logic [31:0] ready;

    // reads see the table before this cycle's write
    assign src1_tag   = tags[lookup1];
    assign src2_tag   = tags[lookup2];
    assign src1_ready = ready[lookup1] | (cdb.valid && cdb.tag == src1_tag);
    assign src2_ready = ready[lookup2] | (cdb.valid && cdb.tag == src2_tag);
    assign old_tag    = tags[alloc_ar];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                tags[i] <= phys_tag_t'(i);   // identity map
            end
            ready <= '1;
        end else begin
            for (int i = 0; i < 32; i++) begin
                if (cdb.valid && tags[i] == cdb.tag) ready[i] <= 1'b1;
            end
            // alloc tag is never on the CDB, no conflict with the wakeup
            if (alloc) begin
                tags[alloc_ar]  <= alloc_tag;
                ready[alloc_ar] <= 1'b0;
            end
        end
    end

endmodule

/* verilog/free_list.sv */
// free physical tag queue
// circular buffer with a count, popped on dispatch and pushed with the
// old tag of each retiring instruction; starts with the upper half of tags
`timescale 1ns/1ps

module free_list (
    input  logic               clock,
    input  logic               reset,
    input  logic               pop,
    input  logic               push,
    input  ooo_pkg::phys_tag_t push_tag,
    output ooo_pkg::phys_tag_t head_tag,
    output logic               empty
);
    import ooo_pkg::*;

    localparam int fl_depth = num_phys_regs / 2;   // 32 tags never mapped at once
    localparam int ptr_w    = $clog2(fl_depth);

    phys_tag_t        queue [fl_depth];
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w:0]   count;

    assign head_tag = queue[head];
    assign empty    = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < fl_depth; i++) begin
                queue[i] <= phys_tag_t'(fl_depth + i);   // tags 32..63
            end
            head  <= '0;
            tail  <= '0;   // full queue, tail wraps onto head
            count <= (ptr_w + 1)'(fl_depth);
        end else begin
            if (pop) head <= head + 1'b1;   // wraps at 32
            if (push) begin
                queue[tail] <= push_tag;
                tail        <= tail + 1'b1;
            end
            count <= count + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
        end
    end

endmodule

/* verilog/reservation_station.sv */
// reservation station for the single ALU
// entries wake on a CDB tag match, the lowest ready entry issues each
// cycle and reads its operands from the physical register file
// a same-cycle CDB match counts as ready, the regfile bypass supplies the value
`timescale 1ns/1ps

module reservation_station #(
    parameter int rs_depth = 8
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               alloc,
    input  ooo_pkg::rs_entry_t entry_in,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::phys_tag_t rda_tag,
    output ooo_pkg::phys_tag_t rdb_tag,
    input  isa_pkg::data_t     rda_value,
    input  isa_pkg::data_t     rdb_value,
    output ooo_pkg::issue_t    issue,
    output logic               full
);
    import ooo_pkg::*;
    import isa_pkg::*;

    localparam int idx_w = $clog2(rs_depth);

    rs_entry_t           entries [rs_depth];
    logic [rs_depth-1:0] valid;
    logic                sel_valid;
    logic [idx_w-1:0]    sel_idx;       // entry going to the ALU
    logic [idx_w-1:0]    free_idx;      // slot for the next dispatch

    function automatic logic woken(phys_tag_t tag, logic rdy, cdb_t bus);
        return rdy | (bus.valid && bus.tag == tag);
    endfunction

    assign full = &valid;   // stall from state only

    ////////////////////
    // select
    ////////////////////
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        free_idx  = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin   // lowest index wins
            if (valid[i] && woken(entries[i].src1_tag, entries[i].src1_ready, cdb)
                    && woken(entries[i].src2_tag, entries[i].src2_ready, cdb)) begin
                sel_valid = 1'b1;
                sel_idx   = idx_w'(i);
            end
            if (!valid[i]) free_idx = idx_w'(i);
        end
    end

    // operand read through the regfile
    assign rda_tag = entries[sel_idx].src1_tag;
    assign rdb_tag = entries[sel_idx].src2_tag;

    always_comb begin
        issue.valid    = sel_valid;
        issue.op       = entries[sel_idx].op;
        issue.dest_tag = entries[sel_idx].dest_tag;
        issue.a        = rda_value;
        issue.b        = (entries[sel_idx].op == op_addi) ? entries[sel_idx].imm : rdb_value;
    end

    ////////////////////
    // entry update
    ////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            entries[i].src1_ready <= woken(entries[i].src1_tag, entries[i].src1_ready, cdb);
            entries[i].src2_ready <= woken(entries[i].src2_tag, entries[i].src2_ready, cdb);
        end
        if (alloc) entries[free_idx] <= entry_in;   // ready bits already forwarded
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (sel_valid) valid[sel_idx] <= 1'b0;  // freed on issue
            if (alloc) valid[free_idx] <= 1'b1;     // never the issuing slot
        end
    end

endmodule

/* verilog/phys_regfile.sv */
// physical register file, 64 words
// two combinational read ports for the RS, written by the CDB,
// a same-cycle CDB write is bypassed to the reads
`timescale 1ns/1ps

module phys_regfile (
    input  logic               clock,
    input  logic               reset,
    input  ooo_pkg::phys_tag_t rda_tag,
    input  ooo_pkg::phys_tag_t rdb_tag,
    input  ooo_pkg::cdb_t      cdb,
    output isa_pkg::data_t     rda_value,
    output isa_pkg::data_t     rdb_value
);
    import ooo_pkg::*;
    import isa_pkg::*;

    data_t regs [num_phys_regs];

    function automatic data_t read_port(phys_tag_t tag);
        return (cdb.valid && cdb.tag == tag) ? cdb.value : regs[tag];   // bypass
    endfunction

    assign rda_value = read_port(rda_tag);
    assign rdb_value = read_port(rdb_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_phys_regs; i++) regs[i] <= '0;   // all arch regs read 0
        end else if (cdb.valid) begin
            regs[cdb.tag] <= cdb.value;
        end
    end

endmodule

/* verilog/alu_fu.sv */
// single-cycle integer ALU
// decodes the opcode, registers result, tag and valid onto the CDB
// one cycle after issue
`timescale 1ns/1ps

module alu_fu (
    input  logic            clock,
    input  logic            reset,
    input  ooo_pkg::issue_t issue,
    output ooo_pkg::cdb_t   cdb
);
    import ooo_pkg::*;
    import isa_pkg::*;

    data_t     result;
    logic      cdb_valid_q;
    phys_tag_t cdb_tag_q;
    data_t     cdb_value_q;

    always_comb begin
        unique case (issue.op)
            op_add, op_addi: result = issue.a + issue.b;   // b holds imm for addi
            op_sub:  result = issue.a - issue.b;
            op_and:  result = issue.a & issue.b;
            op_or:   result = issue.a | issue.b;
            op_xor:  result = issue.a ^ issue.b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) cdb_valid_q <= 1'b0;
        else       cdb_valid_q <= issue.valid;
    end

    always_ff @(posedge clock) begin
        cdb_tag_q   <= issue.dest_tag;
        cdb_value_q <= result;
    end

    assign cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};

endmodule

/* verilog/rob.sv */
// reorder buffer
// circular, filled in program order at dispatch, completed by CDB tag
// match, retires the done head entry one per cycle through a register
// and hands its old tag back to the free list; rob_depth a power of 2
`timescale 1ns/1ps

module rob #(
    parameter int rob_depth = 16
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc,
    input  ooo_pkg::rob_entry_t entry_in,
    input  ooo_pkg::cdb_t       cdb,
    output logic                full,
    output isa_pkg::retire_t    retire,
    output logic                free_push,
    output ooo_pkg::phys_tag_t  free_tag
);
    import ooo_pkg::*;
    import isa_pkg::*;

    localparam int ptr_w = $clog2(rob_depth);

    rob_entry_t           entries [rob_depth];
    logic [rob_depth-1:0] valid;
    logic [ptr_w-1:0]     head, tail;
    logic [ptr_w:0]       count;
    logic                 do_retire;
    logic                 retire_valid_q;
    arch_reg_t            retire_dest_q;
    data_t                retire_value_q;
    phys_tag_t            freed_tag_q;

    assign full      = (count == (ptr_w + 1)'(rob_depth));
    assign do_retire = valid[head] && entries[head].done;

    ////////////////////
    // entries
    ////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < rob_depth; i++) begin
            // new tags in flight are unique, at most one match
            if (valid[i] && cdb.valid && entries[i].new_tag == cdb.tag) begin
                entries[i].done  <= 1'b1;
                entries[i].value <= cdb.value;
            end
        end
        if (alloc) entries[tail] <= entry_in;   // tail slot is never valid here
        retire_dest_q  <= entries[head].dest;
        retire_value_q <= entries[head].value;
        freed_tag_q    <= entries[head].old_tag;
    end

    ////////////////////
    // pointers
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            valid          <= '0;
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            retire_valid_q <= 1'b0;
        end else begin
            if (do_retire) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (alloc) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
            end
            count          <= count + (ptr_w + 1)'(alloc) - (ptr_w + 1)'(do_retire);
            retire_valid_q <= do_retire;
        end
    end

    assign retire    = '{valid: retire_valid_q, dest: retire_dest_q, value: retire_value_q};
    assign free_push = retire_valid_q;   // old tag freed with the retire pulse
    assign free_tag  = freed_tag_q;

endmodule

/* verilog/core_top.sv */
// top level of the out-of-order core
// one instruction in per cycle on inst with a valid/stall handshake,
// one retire pulse per instruction out in program order
// rs_depth and rob_depth are passed down, rob_depth must stay <= 32
`timescale 1ns/1ps

module core_top #(
    parameter int rs_depth  = 8,
    parameter int rob_depth = 16
) (
    input  logic             clock,
    input  logic             reset,
    input  isa_pkg::inst_t   inst,
    output logic             dispatch_stall,
    output isa_pkg::retire_t retire
);
    import ooo_pkg::*;
    import isa_pkg::*;

    logic       alloc;         // single accept strobe
    rs_entry_t  rs_entry;
    rob_entry_t rob_entry;
    logic       rs_full;
    logic       rob_full;
    logic       fl_empty;
    phys_tag_t  free_tag;      // free list head
    phys_tag_t  src1_tag, src2_tag, old_tag;
    logic       src1_ready, src2_ready;
    logic       free_push;     // old tag back from retire
    phys_tag_t  freed_tag;
    phys_tag_t  rda_tag, rdb_tag;
    data_t      rda_value, rdb_value;
    issue_t     issue;
    cdb_t       cdb;

    ////////////////////
    // rename / dispatch
    ////////////////////
    dispatch_stage dispatch0 (
        .inst(inst),
        .rs_full(rs_full),
        .rob_full(rob_full),
        .fl_empty(fl_empty),
        .free_tag(free_tag),
        .src1_tag(src1_tag),
        .src1_ready(src1_ready),
        .src2_tag(src2_tag),
        .src2_ready(src2_ready),
        .old_tag(old_tag),
        .alloc(alloc),
        .rs_entry(rs_entry),
        .rob_entry(rob_entry),
        .dispatch_stall(dispatch_stall)
    );

    map_table map0 (
        .clock(clock),
        .reset(reset),
        .lookup1(inst.src1),
        .lookup2(inst.src2),
        .alloc(alloc),
        .alloc_ar(inst.dest),
        .alloc_tag(free_tag),
        .cdb(cdb),
        .src1_tag(src1_tag),
        .src1_ready(src1_ready),
        .src2_tag(src2_tag),
        .src2_ready(src2_ready),
        .old_tag(old_tag)
    );

    free_list fl0 (
        .clock(clock),
        .reset(reset),
        .pop(alloc),
        .push(free_push),
        .push_tag(freed_tag),
        .head_tag(free_tag),
        .empty(fl_empty)
    );

    ////////////////////
    // issue / execute
    ////////////////////
    reservation_station #(.rs_depth(rs_depth)) rs0 (
        .clock(clock),
        .reset(reset),
        .alloc(alloc),
        .entry_in(rs_entry),
        .cdb(cdb),
        .rda_tag(rda_tag),
        .rdb_tag(rdb_tag),
        .rda_value(rda_value),
        .rdb_value(rdb_value),
        .issue(issue),
        .full(rs_full)
    );

    phys_regfile prf0 (
        .clock(clock),
        .reset(reset),
        .rda_tag(rda_tag),
        .rdb_tag(rdb_tag),
        .cdb(cdb),
        .rda_value(rda_value),
        .rdb_value(rdb_value)
    );

    alu_fu alu0 (
        .clock(clock),
        .reset(reset),
        .issue(issue),
        .cdb(cdb)            // CDB source
    );

    ////////////////////
    // retire
    ////////////////////
    rob #(.rob_depth(rob_depth)) rob0 (
        .clock(clock),
        .reset(reset),
        .alloc(alloc),
        .entry_in(rob_entry),
        .cdb(cdb),
        .full(rob_full),
        .retire(retire),
        .free_push(free_push),
        .free_tag(freed_tag)
    );

endmodule

/* sim/core_tb.sv */
// testbench for the out-of-order core
// replays the instruction stream from sim/core_patterns.hex several times
// through the dispatch port with random idle gaps, and checks every
// retire pulse against the expected dest and value in program order
`timescale 1ns/1ps

module core_tb;
    import isa_pkg::*;

    localparam int num_pats     = 35;
    localparam int num_passes   = 3;     // 105 instructions, tags must recycle
    localparam int stall_limit  = 200;   // cycles
    localparam int retire_limit = 300;   // cycles

    // one line of the pattern file
    typedef struct packed {
        logic [3:0] op;
        logic [7:0] dest;
        logic [7:0] src1;
        logic [7:0] src2;
        data_t      imm;
        data_t      expected;        // dest value after this instruction
    } pattern_t;

    logic        clock;
    logic        reset;
    inst_t       inst;
    logic        dispatch_stall;
    retire_t     retire;

    logic [91:0] pats [num_pats];
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          dispatched;
    int          retired = 0;         // every retire pulse seen
    logic        timed_out;           // stops driver and checker

    core_top dut0 (
        .clock(clock),
        .reset(reset),
        .inst(inst),
        .dispatch_stall(dispatch_stall),
        .retire(retire)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;    // 8 ns
    end

    // counts pulses on its own, apart from the in-order checker
    always @(negedge clock) begin
        if (!reset && retire.valid) retired++;
    end

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////
    // idle after reset
    ////////////////////
    task automatic check_idle();
        int start_errors;
        start_errors = errors;
        repeat (5) begin
            @(negedge clock);
            assert (!dispatch_stall) else begin
                $display("Error: dispatch_stall = %h after reset, expected %h",
                         dispatch_stall, 1'b0);
                errors++;
            end
            assert (!retire.valid) else begin
                $display("Error: retire.valid = %h after reset, expected %h",
                         retire.valid, 1'b0);
                errors++;
            end
        end
        report_test("idle after reset", start_errors);
    endtask

    ////////////////////
    // dispatch driver
    ////////////////////
    task automatic drive_stream();   // entered 1 ns after a rising edge
        pattern_t p;
        int       gap;
        int       waited;
        for (int n = 0; n < num_pats * num_passes; n++) begin
            p   = pats[n % num_pats];
            gap = int'($urandom_range(3, 0));
            repeat (gap) begin
                @(posedge clock);
                #1;
            end
            inst.op    = alu_op_e'(p.op[2:0]);
            inst.dest  = p.dest[4:0];
            inst.src1  = p.src1[4:0];
            inst.src2  = p.src2[4:0];
            inst.imm   = p.imm;
            inst.valid = 1'b1;
            waited     = 0;
            @(negedge clock);                           // stall is settled here
            while (dispatch_stall && waited < stall_limit) begin
                waited++;
                @(negedge clock);
            end
            assert (!dispatch_stall) else begin
                $display("Timeout: dispatch stayed stalled for %0d cycles at instruction %0d",
                         stall_limit, n);
                errors++;
                timed_out = 1'b1;
            end
            if (timed_out) break;
            @(posedge clock);                           // accepted on this edge
            #1;
            inst.valid = 1'b0;
            dispatched++;
        end
        inst = '0;
    endtask

    ////////////////////
    // retire checker
    ////////////////////
    task automatic check_stream();
        pattern_t p;
        int       waited;
        int       pass_errors;
        pass_errors = errors;
        for (int n = 0; n < num_pats * num_passes; n++) begin
            if (timed_out) break;
            p      = pats[n % num_pats];
            waited = 0;
            @(negedge clock);
            while (!retire.valid && waited < retire_limit) begin
                waited++;
                @(negedge clock);
            end
            assert (retire.valid) else begin
                $display("Timeout: no retire within %0d cycles for instruction %0d",
                         retire_limit, n);
                errors++;
                timed_out = 1'b1;
            end
            if (timed_out) break;
            assert (retire.dest == p.dest[4:0]) else begin
                $display("Error: retire.dest = %h, expected %h at instruction %0d",
                         retire.dest, p.dest[4:0], n);
                errors++;
            end
            assert (retire.value == p.expected) else begin
                $display("Error: retire.value = %h, expected %h at instruction %0d",
                         retire.value, p.expected, n);
                errors++;
            end
            if (n % num_pats == num_pats - 1) begin   // end of one replay
                report_test($sformatf("pattern pass %0d", n / num_pats), pass_errors);
                pass_errors = errors;
            end
        end
    endtask

    initial begin
        int recycle_errors;
        void'($urandom(32'hb21b_3013));
        inst         = '0;
        reset        = 1'b1;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        dispatched   = 0;
        timed_out    = 1'b0;
        $readmemh("sim/core_patterns.hex", pats);

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        check_idle();
        @(posedge clock);
        #1;
        fork
            drive_stream();
            check_stream();
        join

        // nothing retires beyond the stream, counts agree
        recycle_errors = errors;
        repeat (20) begin
            @(negedge clock);
            assert (!retire.valid) else begin
                $display("Error: retire.valid = %h after the last instruction, expected %h",
                         retire.valid, 1'b0);
                errors++;
            end
        end
        assert (retired == dispatched && dispatched == num_pats * num_passes) else begin
            $display("retired %0d instructions but dispatched %0d of %0d",
                     retired, dispatched, num_pats * num_passes);
            errors++;
        end
        report_test($sformatf("tag recycling over %0d instructions", num_pats * num_passes),
                    recycle_errors);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/isa_pkg.sv
verilog/ooo_pkg.sv
verilog/dispatch_stage.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/reservation_station.sv
verilog/phys_regfile.sv
verilog/alu_fu.sv
verilog/rob.sv
verilog/core_top.sv
sim/core_tb.sv

/* run.sh */
#!/bin/sh
# build the core testbench with Verilator, run it, judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module core_tb -f filelist.f -o core_sim \
    > sim.log 2>&1 \
    && ./obj_dir/core_sim >> sim.log 2>&1

grep -q "^=== PASS ===$" sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* sim/core_patterns.hex */
// columns: op_dest_src1_src2_imm_expected, one instruction per line
// op 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 addi; expected is the retired dest value
// clear every register used below so the stream can be replayed
4_00_00_00_00000000_00000000
4_01_01_01_00000000_00000000
4_02_02_02_00000000_00000000
4_03_03_03_00000000_00000000
4_04_04_04_00000000_00000000
4_05_05_05_00000000_00000000
4_06_06_06_00000000_00000000
4_1f_1f_1f_00000000_00000000
// each opcode once
5_01_00_00_12345678_12345678
5_02_00_00_0f0f00ff_0f0f00ff
0_03_01_02_00000000_21435777
1_04_01_02_00000000_03255579
2_05_01_02_00000000_02040078
3_06_01_02_00000000_1f3f56ff
4_1f_01_02_00000000_1d3b5687
// back-to-back dependent chain
5_01_01_00_00000001_12345679
0_01_01_01_00000000_2468acf2
1_02_01_03_00000000_0325557b
4_03_02_01_00000000_274df989
2_04_03_06_00000000_070d5089
3_05_04_00_00000000_070d5089
// repeated writes to r6 and r0 mixed with reads of old and new values
5_06_05_00_00000010_070d5099
5_00_06_00_ffffffff_070d5098
0_06_06_00_00000000_0e1aa131
1_00_00_06_00000000_f8f2af67
5_06_00_00_00000000_f8f2af67
4_1f_1f_06_00000000_e5c9f9e0
5_01_1f_00_00000020_e5c9fa00
0_02_01_01_00000000_cb93f400
1_03_03_03_00000000_00000000
3_03_03_02_00000000_cb93f400
2_04_02_01_00000000_c181f000
5_05_05_00_7fffffff_870d5088
1_01_06_05_00000000_71e55edf
0_02_01_04_00000000_33674edf
